// File: compile.f
src/fmadPkg.sv
src/mulIf.sv
src/radix16Mult.sv
src/addendPrep.sv
src/fmadCombine.sv
src/fmadControl.sv
src/fmad.sv
testbench/fmadChecker.sv
testbench/fmadTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := fmadTb
FILELIST  := compile.f
FLAGS     := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall
BUILDDIR  := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

run: build
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	@grep -q "Testbench passed" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILDDIR) $(LOG)

// File: testbench/fmadTb.sv
// Testbench for the integer FMA block with LFSR stimulus, a cycle limit and the final verdict.

`timescale 1ns/100ps

module fmadTb;
  import fmadPkg::*;

  localparam int RANDOM_OPS  = 200;
  localparam int CORNER_OPS  = 12;                    // three value sets, four sign modes each.
  localparam int TOTAL_TESTS = RANDOM_OPS + CORNER_OPS + 1;
  localparam int CYCLE_LIMIT = (RANDOM_OPS + CORNER_OPS) * 10 + 100;

  logic                 clock;
  logic                 reset;
  logic                 start;
  logic                 sub;
  logic                 negate;
  logic [MUL_WIDTH-1:0] mulIn1;
  logic [MUL_WIDTH-1:0] mulIn2;
  logic [OUT_WIDTH-1:0] addIn;
  logic [OUT_WIDTH-1:0] result;
  logic                 done;
  logic                 cornerMode;
  logic                 finished;
  logic                 summaryDone;
  int                   errorCount;
  int                   testCount;
  int                   cycleCount;
  logic [15:0]          lfsrState;

  fmad i_fmad (
    .clock  (clock),
    .reset  (reset),
    .start  (start),
    .sub    (sub),
    .negate (negate),
    .mulIn1 (mulIn1),
    .mulIn2 (mulIn2),
    .addIn  (addIn),
    .result (result),
    .done   (done)
  );

  fmadChecker iChecker (
    .clock       (clock),
    .reset       (reset),
    .start       (start),
    .sub         (sub),
    .negate      (negate),
    .mulIn1      (mulIn1),
    .mulIn2      (mulIn2),
    .addIn       (addIn),
    .result      (result),
    .done        (done),
    .cornerMode  (cornerMode),
    .finished    (finished),
    .errorCount  (errorCount),
    .testCount   (testCount),
    .summaryDone (summaryDone)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;                        // 8 ns period.
  end

  // **************************************************
  // stimulus helpers
  // **************************************************

  // taps for x^16 + x^14 + x^13 + x^11, a maximal length sequence.
  function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic takeBits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value     = {value[30:0], lfsrState[0]};
    end
  endtask

  task automatic pickCorner(
    input  int                   index,
    output logic [MUL_WIDTH-1:0] a,
    output logic [MUL_WIDTH-1:0] b,
    output logic [OUT_WIDTH-1:0] addend
  );
    a      = '1;
    b      = '1;
    addend = '1;
    if (index / 4 == 0) begin
      addend = '0;                                    // largest product alone.
    end else if (index / 4 == 1) begin
      a = '0;
      b = '0;
    end
  endtask

  task automatic runOperation(
    input logic [MUL_WIDTH-1:0] a,
    input logic [MUL_WIDTH-1:0] b,
    input logic [OUT_WIDTH-1:0] addend,
    input logic                 subOp,
    input logic                 negOp
  );
    logic [31:0] bits;
    start  <= 1'b1;
    mulIn1 <= a;
    mulIn2 <= b;
    addIn  <= addend;
    sub    <= subOp;
    negate <= negOp;
    @(posedge clock);
    start <= 1'b0;
    takeBits(OUT_WIDTH + 2, bits);                    // the running operation must ignore these.
    mulIn1 <= bits[MUL_WIDTH-1:0];
    mulIn2 <= bits[OUT_WIDTH-1:MUL_WIDTH];
    sub    <= bits[OUT_WIDTH];
    negate <= bits[OUT_WIDTH+1];
    takeBits(OUT_WIDTH, bits);
    addIn <= bits[OUT_WIDTH-1:0];
    @(posedge clock);
    while (!done) begin
      @(posedge clock);
    end
    takeBits(2, bits);
    repeat (bits) @(posedge clock);                   // idle gap while done holds.
  endtask

  // **************************************************
  // test sequence
  // **************************************************

  initial begin
    logic [31:0]          bits;
    logic [MUL_WIDTH-1:0] opA;
    logic [MUL_WIDTH-1:0] opB;
    logic [OUT_WIDTH-1:0] addend;
    reset      = 1'b1;
    start      = 1'b0;
    sub        = 1'b0;
    negate     = 1'b0;
    mulIn1     = '0;
    mulIn2     = '0;
    addIn      = '0;
    cornerMode = 1'b0;
    finished   = 1'b0;
    lfsrState  = 16'd92;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    repeat (2) @(posedge clock);
    for (int n = 0; n < RANDOM_OPS; n++) begin
      takeBits(MUL_WIDTH, bits);
      opA = bits[MUL_WIDTH-1:0];
      takeBits(MUL_WIDTH, bits);
      opB = bits[MUL_WIDTH-1:0];
      takeBits(OUT_WIDTH, bits);
      addend = bits[OUT_WIDTH-1:0];
      takeBits(2, bits);
      runOperation(opA, opB, addend, bits[1], bits[0]);
    end
    cornerMode <= 1'b1;
    for (int n = 0; n < CORNER_OPS; n++) begin
      pickCorner(n, opA, opB, addend);
      runOperation(opA, opB, addend, n[0], n[1]);
    end
    finished <= 1'b1;
    @(posedge clock);
    while (!summaryDone) begin
      @(posedge clock);
    end
    if (errorCount == 0 && testCount == TOTAL_TESTS) begin
      $display("Testbench passed");
    end else begin
      if (testCount != TOTAL_TESTS) begin
        $display("only %0d of %0d tests completed", testCount, TOTAL_TESTS);
      end
      $display("Testbench failed");
    end
    $finish;
  end

  initial begin
    cycleCount = 0;
    forever begin
      @(posedge clock);
      cycleCount++;
      if (cycleCount > CYCLE_LIMIT) begin
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Testbench failed");
        $finish;
      end
    end
  end

endmodule : fmadTb

// File: testbench/fmadChecker.sv
// Checker that models each FMA operation and compares latency, result and result hold.

`timescale 1ns/100ps

module fmadChecker (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           start,
  input  logic                           sub,
  input  logic                           negate,
  input  logic [fmadPkg::MUL_WIDTH-1:0]  mulIn1,
  input  logic [fmadPkg::MUL_WIDTH-1:0]  mulIn2,
  input  logic [fmadPkg::OUT_WIDTH-1:0]  addIn,
  input  logic [fmadPkg::OUT_WIDTH-1:0]  result,
  input  logic                           done,
  input  logic                           cornerMode,
  input  logic                           finished,
  output int                             errorCount,
  output int                             testCount,
  output logic                           summaryDone
);
  import fmadPkg::*;

  localparam int LATENCY = 6;                         // cycles from sampled start to done.

  logic                 resetSeen;
  logic                 busy;
  logic                 holding;
  int                   elapsed;
  int                   opErrors;
  int                   failedCount;
  int                   randomIndex;
  int                   cornerIndex;
  logic [OUT_WIDTH-1:0] expected;
  logic [OUT_WIDTH-1:0] heldResult;
  string                testName;

  // product, sign flipped on negate, then the addend added or taken away.
  function automatic logic [OUT_WIDTH-1:0] modelFmad(
    input logic [MUL_WIDTH-1:0] a,
    input logic [MUL_WIDTH-1:0] b,
    input logic [OUT_WIDTH-1:0] addend,
    input logic                 subOp,
    input logic                 negOp
  );
    logic [OUT_WIDTH-1:0] product;
    product = OUT_WIDTH'(a) * OUT_WIDTH'(b);
    if (negOp) begin
      product = OUT_WIDTH'(0) - product;
    end
    if (subOp) begin
      return product - addend;
    end
    return product + addend;
  endfunction

  task flagMismatch(input string what, input logic [31:0] want, input logic [31:0] got);
    $display("ERR %s %s: expected 0x%0h actual 0x%0h", testName, what, want, got);
    errorCount++;
    opErrors++;
  endtask

  task flagProblem(input string text);
    $display("%s: %s", testName, text);
    errorCount++;
    opErrors++;
  endtask

  task closeTest();
    testCount++;
    if (opErrors == 0) begin
      $display("%s: ok", testName);
    end else begin
      failedCount++;
      $display("%s: failed with %0d errors", testName, opErrors);
    end
  endtask

  // **************************************************
  // sampling on every rising edge
  // **************************************************

  always @(posedge clock) begin
    if (reset) begin
      resetSeen   = 1'b1;
      busy        = 1'b0;
      holding     = 1'b0;
      errorCount  = 0;
      testCount   = 0;
      failedCount = 0;
      randomIndex = 0;
      cornerIndex = 0;
      summaryDone <= 1'b0;
    end else begin
      if (resetSeen) begin
        resetSeen = 1'b0;
        testName  = "reset";
        opErrors  = 0;
        if (done) begin
          flagProblem("done is high right after reset");
        end
        if (result !== '0) begin
          flagMismatch("result", '0, 32'(result));
        end
        closeTest();
      end
      if (holding) begin
        if (done !== 1'b1) begin
          flagProblem("done dropped before a new start");
          holding = 1'b0;
          closeTest();
        end else if (result !== heldResult) begin
          flagMismatch("held result", 32'(heldResult), 32'(result));
        end
      end
      if (busy) begin
        elapsed++;
        if (done) begin
          if (elapsed != LATENCY) begin
            flagMismatch("latency", LATENCY, elapsed);
          end
          if (result !== expected) begin
            flagMismatch("result", 32'(expected), 32'(result));
          end
          busy       = 1'b0;
          holding    = 1'b1;
          heldResult = result;
        end else if (elapsed > LATENCY) begin
          flagProblem("done never rose after the start");
          busy = 1'b0;
          closeTest();
        end
      end
      if (start) begin
        if (holding) begin
          holding = 1'b0;
          closeTest();
        end
        if (cornerMode) begin
          testName = $sformatf("corner %0d", cornerIndex);
          cornerIndex++;
        end else begin
          testName = $sformatf("random %0d", randomIndex);
          randomIndex++;
        end
        expected = modelFmad(mulIn1, mulIn2, addIn, sub, negate);   // inputs as latched.
        busy     = 1'b1;
        elapsed  = 0;
        opErrors = 0;
      end
      if (finished && !summaryDone) begin
        if (holding) begin
          holding = 1'b0;
          closeTest();
        end
        $display("tests: %0d run, %0d passed, %0d failed, %0d check errors",
                 testCount, testCount - failedCount, failedCount, errorCount);
        summaryDone <= 1'b1;
      end
    end
  end

endmodule : fmadChecker

// File: src/fmad.sv
// Integer fused multiply-add top level joining the multiplier, addend path, combiner and FSM.

`timescale 1ns/100ps

module fmad (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           start,
  input  logic                           sub,
  input  logic                           negate,
  input  logic [fmadPkg::MUL_WIDTH-1:0]  mulIn1,
  input  logic [fmadPkg::MUL_WIDTH-1:0]  mulIn2,
  input  logic [fmadPkg::OUT_WIDTH-1:0]  addIn,
  output logic [fmadPkg::OUT_WIDTH-1:0]  result,
  output logic                           done
);
  import fmadPkg::*;

  logic [OUT_WIDTH-1:0] addendTerm;
  logic                 addEnable;

  mulIf mulBus ();

  // operands stay fixed for the whole operation.
  always_ff @(posedge clock) begin
    if (start) begin
      mulBus.operandA <= mulIn1;
      mulBus.operandB <= mulIn2;
    end
  end

  radix16Mult iMult (
    .clock (clock),
    .reset (reset),
    .mul   (mulBus.slave)
  );

  addendPrep iAddend (
    .clock      (clock),
    .reset      (reset),
    .start      (start),
    .sub        (sub),
    .addIn      (addIn),
    .addendTerm (addendTerm)
  );

  fmadCombine iCombine (
    .clock      (clock),
    .reset      (reset),
    .start      (start),
    .negate     (negate),
    .addEnable  (addEnable),
    .addendTerm (addendTerm),
    .mul        (mulBus.consumer),
    .result     (result)
  );

  fmadControl iControl (
    .clock     (clock),
    .reset     (reset),
    .start     (start),
    .mul       (mulBus.master),
    .addEnable (addEnable),
    .done      (done)
  );

endmodule : fmad

// File: src/fmadControl.sv
// Sequencing FSM that kicks the multiplier, waits for it, enables the add and raises done.

`timescale 1ns/100ps

module fmadControl (
  input  logic clock,
  input  logic reset,
  input  logic start,
  mulIf.master mul,
  output logic addEnable,
  output logic done
);
  import fmadPkg::*;

  fmadState_t state;
  fmadState_t nextState;

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      state <= WAIT;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      WAIT: begin
        if (start) begin
          nextState = KICK;
        end
      end
      KICK: nextState = MUL;
      MUL: begin
        if (mul.done) begin
          nextState = ADD;
        end
      end
      ADD: nextState = DONE;
      DONE: begin
        if (start) begin
          nextState = KICK;                           // back to back operations skip WAIT.
        end
      end
      default: nextState = WAIT;
    endcase
  end

  assign mul.start = (state == KICK);
  assign addEnable = (state == ADD);
  assign done      = (state == DONE);

  // **************************************************
  // protocol checks
  // **************************************************

  // every multiplier done pulse opens exactly one add cycle.
  addAfterMulDone: assert property (
    @(posedge clock) disable iff (reset)
    mul.done |=> addEnable ##1 !addEnable
  );

  startOnlyWhenIdle: assert property (
    @(posedge clock) disable iff (reset)
    start |-> (state == WAIT) || (state == DONE)
  );

endmodule : fmadControl

// File: src/fmadCombine.sv
// Combiner that applies the negate control to the product and adds in the addend term.

`timescale 1ns/100ps

module fmadCombine (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           start,
  input  logic                           negate,
  input  logic                           addEnable,
  input  logic [fmadPkg::OUT_WIDTH-1:0]  addendTerm,
  mulIf.consumer                         mul,
  output logic [fmadPkg::OUT_WIDTH-1:0]  result
);
  import fmadPkg::*;

  logic                 negateReg;
  logic [OUT_WIDTH-1:0] productTerm;

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      negateReg <= 1'b0;
    end else if (start) begin
      negateReg <= negate;
    end
  end

  always_comb begin
    if (negateReg) begin
      productTerm = -mul.product;
    end else begin
      productTerm = mul.product;
    end
  end

  // **************************************************
  // result register
  // **************************************************

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      result <= '0;
    end else if (start) begin
      result <= '0;                                   // cleared for the new operation.
    end else if (addEnable) begin
      result <= productTerm + addendTerm;             // wraps modulo 2 to the 22.
    end
  end

endmodule : fmadCombine

// File: src/addendPrep.sv
// Addend preparation that captures the addend and sub at start and forms the signed term.

`timescale 1ns/100ps

module addendPrep (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           start,
  input  logic                           sub,
  input  logic [fmadPkg::OUT_WIDTH-1:0]  addIn,
  output logic [fmadPkg::OUT_WIDTH-1:0]  addendTerm
);
  import fmadPkg::*;

  logic [OUT_WIDTH-1:0] addendReg;
  logic                 subReg;

  // **************************************************
  // capture at start
  // **************************************************

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      subReg <= 1'b0;
    end else if (start) begin
      subReg <= sub;                                  // later changes on sub are ignored.
    end
  end

  always_ff @(posedge clock) begin
    if (start) begin
      addendReg <= addIn;
    end
  end

  // Two's-complement negation gives subtraction once the combiner adds the term.
  always_comb begin
    if (subReg) begin
      addendTerm = -addendReg;
    end else begin
      addendTerm = addendReg;
    end
  end

endmodule : addendPrep

// File: src/radix16Mult.sv
// Iterative radix-16 multiplier that retires one 4-bit digit of operand B per cycle.

`timescale 1ns/100ps

module radix16Mult (
  input logic clock,
  input logic reset,
  mulIf.slave mul
);
  import fmadPkg::*;

  logic                           running;
  logic [$clog2(MUL_STEPS)-1:0]   stepCount;
  logic                           lastStep;
  logic [OUT_WIDTH-1:0]           multiplicand;   // operand A, moved up one digit per step.
  logic [MUL_WIDTH-1:0]           multiplier;     // operand B, low digit consumed each step.
  logic [OUT_WIDTH-1:0]           partialSum;
  logic [DIGIT_WIDTH-1:0]         digit;
  logic [OUT_WIDTH-1:0]           stepTerm;

  assign digit    = multiplier[DIGIT_WIDTH-1:0];
  assign stepTerm = multiplicand * OUT_WIDTH'(digit);   // already shifted into place.
  assign lastStep = running && (int'(stepCount) == MUL_STEPS - 1);

  // **************************************************
  // step sequencing
  // **************************************************

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      running   <= 1'b0;
      stepCount <= '0;
    end else if (mul.start) begin
      running   <= 1'b1;
      stepCount <= '0;
    end else if (running) begin
      stepCount <= stepCount + 1'b1;
      if (lastStep) begin
        running <= 1'b0;                              // product is final after this edge.
      end
    end
  end

  // **************************************************
  // shift and accumulate
  // **************************************************

  always_ff @(posedge clock) begin
    if (mul.start) begin
      partialSum   <= '0;
      multiplicand <= OUT_WIDTH'(mul.operandA);
      multiplier   <= mul.operandB;
    end else if (running) begin
      partialSum   <= partialSum + stepTerm;
      multiplicand <= multiplicand << DIGIT_WIDTH;
      multiplier   <= multiplier >> DIGIT_WIDTH;
    end
  end

  assign mul.product = partialSum;
  assign mul.done    = lastStep;

  // Done must land exactly MUL_STEPS cycles after the kick.
  doneAfterSteps: assert property (
    @(posedge clock) disable iff (reset)
    mul.done |-> $past(mul.start, MUL_STEPS)
  );

  noStartWhileBusy: assert property (
    @(posedge clock) disable iff (reset)
    mul.start |-> !running
  );

endmodule : radix16Mult

// File: src/mulIf.sv
// Multiplier bus carrying the start strobe, both operands, the product and the done pulse.

`timescale 1ns/100ps

interface mulIf;
  import fmadPkg::*;

  logic                 start;      // one-cycle kick from the controller.
  logic [MUL_WIDTH-1:0] operandA;
  logic [MUL_WIDTH-1:0] operandB;
  logic [OUT_WIDTH-1:0] product;    // holds until the next start.
  logic                 done;       // one-cycle pulse on the last digit step.

  modport master (
    output start,
    input  done
  );

  modport slave (
    input  start,
    input  operandA,
    input  operandB,
    output product,
    output done
  );

  modport consumer (
    input product,
    input done
  );

endinterface : mulIf

// File: src/fmadPkg.sv
// Shared widths, digit step count and controller state encoding for the integer FMA block.

package fmadPkg;

  // **************************************************
  // datapath widths
  // **************************************************

  localparam int FRAC_WIDTH  = 10;               // fraction bits of a half-precision value.
  localparam int MUL_WIDTH   = FRAC_WIDTH + 1;   // fraction plus the hidden bit.
  localparam int OUT_WIDTH   = 2 * MUL_WIDTH;    // full product, addend and result width.

  // **************************************************
  // multiplier stepping
  // **************************************************

  localparam int DIGIT_WIDTH = 4;                // one radix-16 digit per step.
  localparam int MUL_STEPS   = (MUL_WIDTH + DIGIT_WIDTH - 1) / DIGIT_WIDTH;

  // **************************************************
  // controller states
  // **************************************************

  typedef enum logic [2:0] {
    WAIT,
    KICK,
    MUL,
    ADD,
    DONE
  } fmadState_t;

endpackage : fmadPkg
